/* hw/hdc_pkg.sv */
`default_nettype none

package hdc_pkg;

    // ----------------------------------------------------------------------
    // hypervector geometry
    // ----------------------------------------------------------------------

    // full hypervector width
    localparam int hv_width = 128;

    // one generator word per chunk
    localparam int chunk_width = 32;
    localparam int chunks_per_hv = hv_width / chunk_width;

    // depth of the item memory
    localparam int item_count_max = 16;

    // xorshift32 start value, reloaded whenever gen drops
    localparam logic [chunk_width-1:0] xorshift_seed = 32'd2463534242;

    // ----------------------------------------------------------------------
    // datapath types
    // ----------------------------------------------------------------------

    typedef logic [hv_width-1:0] hv_t;
    typedef logic [$clog2(item_count_max)-1:0] item_addr_t;
    typedef logic [$clog2(chunks_per_hv)-1:0] chunk_idx_t;

    // generator to memory, one strobe per finished item
    typedef struct packed {
        logic we;
        item_addr_t addr;
        hv_t hv;
    } item_wr_t;

    // output stream beat
    typedef struct packed {
        hv_t hv;
        logic last;
    } hv_beat_t;

    // mode bits, gen in bit 0 and run in bit 1
    typedef struct packed {
        logic run;
        logic gen;
    } mode_t;

endpackage

`default_nettype wire

/* hw/axil_pkg.sv */
`default_nettype none

package axil_pkg;

    // ----------------------------------------------------------------------
    // register map
    // ----------------------------------------------------------------------

    // byte address bits decoded by the slave
    localparam int reg_addr_width = 12;

    // word aligned register offsets
    localparam logic [reg_addr_width-1:0] mode_addr = 12'h000;
    localparam logic [reg_addr_width-1:0] count_addr = 12'h004;

    // ----------------------------------------------------------------------
    // slave FSM
    // ----------------------------------------------------------------------

    // addr_only and data_only wait for the other half of a write
    typedef enum logic [2:0] {
        idle,
        addr_only,
        data_only,
        write_resp,
        read_fetch,
        read_resp
    } axil_state_t;

    // ----------------------------------------------------------------------
    // register word views
    // ----------------------------------------------------------------------

    // same 32 bits read as a mode word or as a count word
    typedef union packed {
        struct packed {
            logic [29:0] spare;
            hdc_pkg::mode_t mode;
        } mode_word;
        struct packed {
            logic [26:0] spare;
            logic [4:0] count;
        } count_word;
    } reg_word_u;

endpackage

`default_nettype wire

/* hw/hdc_axil_regs.sv */
`default_nettype none

module hdc_axil_regs (
    input  wire logic                                AXIS_ACLK,
    input  wire logic                                S_AXI_ARESETN,
    // write address and data
    input  wire logic [axil_pkg::reg_addr_width-1:0] awaddr,
    input  wire logic                                awvalid,
    output logic                                     awready,
    input  wire logic [31:0]                         wdata,
    input  wire logic                                wvalid,
    output logic                                     wready,
    output logic                                     bvalid,
    input  wire logic                                bready,
    // read address and data
    input  wire logic [axil_pkg::reg_addr_width-1:0] araddr,
    input  wire logic                                arvalid,
    output logic                                     arready,
    output logic [31:0]                              rdata,
    output logic                                     rvalid,
    input  wire logic                                rready,
    // generator handshake
    input  wire logic                                gen_done,
    output hdc_pkg::mode_t                           mode,
    output logic [4:0]                               item_count
);
    import axil_pkg::*;
    import hdc_pkg::*;

    axil_state_t state;

    // word aligned latched addresses
    logic [reg_addr_width-1:2] aw_addr_q;
    logic [reg_addr_width-1:2] ar_addr_q;
    logic [31:0] w_data_q;

    // view of the write on the cycle it completes
    logic [reg_addr_width-1:0] wr_addr;
    reg_word_u wr_word;
    logic wr_fire;
    logic [4:0] count_wr;
    reg_word_u rd_word;

    // ----------------------------------------------------------------------
    // handshake outputs, straight from the state
    // ----------------------------------------------------------------------

    assign awready = (state == idle) || (state == data_only);
    assign wready = (state == idle) || (state == addr_only);
    assign arready = (state == idle);
    assign bvalid = (state == write_resp);
    assign rvalid = (state == read_resp);

    // latched half when one side arrived early, bus value otherwise
    assign wr_addr = (state == addr_only) ? {aw_addr_q, 2'b00}
                                          : {awaddr[reg_addr_width-1:2], 2'b00};
    assign wr_word = (state == data_only) ? w_data_q : wdata;

    // every way into write_resp
    assign wr_fire = (state == idle && awvalid && wvalid)
                  || (state == addr_only && wvalid)
                  || (state == data_only && awvalid);

    // FSM
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    // writes win over a read in the same cycle
                    if (awvalid && wvalid) state <= write_resp;
                    else if (awvalid) state <= addr_only;
                    else if (wvalid) state <= data_only;
                    else if (arvalid) state <= read_fetch;
                end
                addr_only: if (wvalid) state <= write_resp;
                data_only: if (awvalid) state <= write_resp;
                write_resp: if (bready) state <= idle;
                // rdata is loaded here
                read_fetch: state <= read_resp;
                read_resp: if (rready) state <= idle;
                default: state <= idle;
            endcase
        end
    end

    // capture whichever half shows up first in idle
    always_ff @(posedge AXIS_ACLK) begin
        if (state == idle && awvalid) aw_addr_q <= awaddr[reg_addr_width-1:2];
        if (state == idle && wvalid) w_data_q <= wdata;
        if (state == idle && arvalid) ar_addr_q <= araddr[reg_addr_width-1:2];
    end

    // ----------------------------------------------------------------------
    // mode and item count
    // ----------------------------------------------------------------------

    // saturate at item_count_max, upper bits count too
    assign count_wr = (|wr_word.count_word.spare || wr_word.count_word.count > item_count_max)
                    ? 5'(item_count_max) : wr_word.count_word.count;

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            mode <= '0;
            item_count <= '0;
        end else begin
            if (wr_fire && wr_addr == mode_addr) begin
                mode <= wr_word.mode_word.mode;
            end else if (gen_done) begin
                // generator finished, drop back to idle mode
                mode.gen <= 1'b0;
            end
            if (wr_fire && wr_addr == count_addr) begin
                item_count <= count_wr;
            end
        end
    end

    // readback mux, unmapped addresses read zero
    always_comb begin
        rd_word = '0;
        if ({ar_addr_q, 2'b00} == mode_addr) begin
            rd_word.mode_word.mode = mode;
        end else if ({ar_addr_q, 2'b00} == count_addr) begin
            rd_word.count_word.count = item_count;
        end
    end

    always_ff @(posedge AXIS_ACLK) begin
        if (state == read_fetch) rdata <= rd_word;
    end

endmodule

`default_nettype wire

/* hw/hdc_item_gen.sv */
`default_nettype none

module hdc_item_gen (
    input  wire logic           AXIS_ACLK,
    input  wire logic           S_AXI_ARESETN,
    input  wire hdc_pkg::mode_t mode,
    input  wire logic [4:0]     item_count,
    output hdc_pkg::item_wr_t   item_wr,
    output logic                gen_done
);
    import hdc_pkg::*;

    logic [chunk_width-1:0] xs_q;
    logic [chunk_width-1:0] xs_next;
    chunk_idx_t chunk_idx;
    item_addr_t item_addr;
    // item under assembly
    hv_t hv_q;
    // write strobe, one cycle behind the last chunk
    logic wr_q;

    // shift order 13 left, 17 right, 5 left
    function automatic logic [chunk_width-1:0] xorshift32(input logic [chunk_width-1:0] x);
        logic [chunk_width-1:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    assign xs_next = xorshift32(xs_q);

    // ----------------------------------------------------------------------
    // sequencing
    // ----------------------------------------------------------------------

    // everything restarts from the seed while gen is low
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN || !mode.gen) begin
            xs_q <= xorshift_seed;
            chunk_idx <= '0;
            item_addr <= '0;
            wr_q <= 1'b0;
        end else begin
            xs_q <= xs_next;
            chunk_idx <= chunk_idx + 1'b1;
            wr_q <= (chunk_idx == chunk_idx_t'(chunks_per_hv - 1));
            // next item once the current one is written
            if (wr_q) item_addr <= item_addr + 1'b1;
        end
    end

    // chunk 0 in the low word
    always_ff @(posedge AXIS_ACLK) begin
        if (mode.gen) hv_q[chunk_idx*chunk_width +: chunk_width] <= xs_next;
    end

    // hv_q still holds the full item in the strobe cycle
    assign item_wr = '{we: wr_q, addr: item_addr, hv: hv_q};

    // ----------------------------------------------------------------------
    // completion
    // ----------------------------------------------------------------------

    // zero count ends at once, otherwise on the last write
    assign gen_done = mode.gen
                   && ((item_count == '0)
                    || (wr_q && {1'b0, item_addr} == item_count - 5'd1));

endmodule

`default_nettype wire

/* hw/hdc_item_memory.sv */
`default_nettype none

module hdc_item_memory (
    input  wire logic               AXIS_ACLK,
    input  wire hdc_pkg::item_wr_t  item_wr,
    input  wire hdc_pkg::item_addr_t rd_addr,
    output hdc_pkg::hv_t            rd_data
);
    import hdc_pkg::*;

    // one hypervector per item
    hv_t mem [item_count_max];

    // write port, generator side
    always_ff @(posedge AXIS_ACLK) begin
        if (item_wr.we) mem[item_wr.addr] <= item_wr.hv;
    end

    // read port, one cycle latency
    // reads every cycle so a held address keeps its data
    always_ff @(posedge AXIS_ACLK) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

/* hw/hdc_item_lookup.sv */
`default_nettype none

module hdc_item_lookup (
    input  wire logic               AXIS_ACLK,
    input  wire logic               S_AXI_ARESETN,
    input  wire hdc_pkg::mode_t     mode,
    // address beat in
    input  wire hdc_pkg::item_addr_t s_tdata,
    input  wire logic               s_tlast,
    input  wire logic               s_tvalid,
    output logic                    s_tready,
    // memory read port
    output hdc_pkg::item_addr_t     rd_addr,
    input  wire hdc_pkg::hv_t       rd_data,
    // hypervector beat out
    output hdc_pkg::hv_beat_t       m_beat,
    output logic                    m_tvalid,
    input  wire logic               m_tready
);
    import hdc_pkg::*;

    // whole pipe moves on this
    logic advance;

    // read stage, data arrives from memory in this stage
    logic s1_valid;
    logic s1_last;
    item_addr_t s1_addr;

    assign advance = !m_tvalid || m_tready;
    assign s_tready = mode.run && advance;

    // on a stall keep reading the held address
    assign rd_addr = advance ? s_tdata : s1_addr;

    // ----------------------------------------------------------------------
    // valid chain
    // ----------------------------------------------------------------------

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            s1_valid <= 1'b0;
            m_tvalid <= 1'b0;
        end else if (advance) begin
            s1_valid <= s_tvalid && s_tready;
            m_tvalid <= s1_valid;
        end
    end

    // ----------------------------------------------------------------------
    // payload
    // ----------------------------------------------------------------------

    // last travels beside the address, then beside the data
    always_ff @(posedge AXIS_ACLK) begin
        if (advance) begin
            s1_last <= s_tlast;
            s1_addr <= s_tdata;
            m_beat <= '{hv: rd_data, last: s1_last};
        end
    end

endmodule

`default_nettype wire

/* hw/hdc_item_top.sv */
`default_nettype none

module hdc_item_top (
    input  wire logic                                AXIS_ACLK,
    input  wire logic                                S_AXI_ARESETN,
    // AXI-Lite control slave
    input  wire logic [axil_pkg::reg_addr_width-1:0] S_AXI_AWADDR,
    input  wire logic                                S_AXI_AWVALID,
    output logic                                     S_AXI_AWREADY,
    input  wire logic [31:0]                         S_AXI_WDATA,
    input  wire logic                                S_AXI_WVALID,
    output logic                                     S_AXI_WREADY,
    output logic                                     S_AXI_BVALID,
    input  wire logic                                S_AXI_BREADY,
    input  wire logic [axil_pkg::reg_addr_width-1:0] S_AXI_ARADDR,
    input  wire logic                                S_AXI_ARVALID,
    output logic                                     S_AXI_ARREADY,
    output logic [31:0]                              S_AXI_RDATA,
    output logic                                     S_AXI_RVALID,
    input  wire logic                                S_AXI_RREADY,
    // item address stream in, address in the low bits
    input  wire logic [hdc_pkg::chunk_width-1:0]     S_AXIS_TDATA,
    input  wire logic                                S_AXIS_TLAST,
    input  wire logic                                S_AXIS_TVALID,
    output logic                                     S_AXIS_TREADY,
    // hypervector stream out
    output logic [hdc_pkg::hv_width-1:0]             M_AXIS_TDATA,
    output logic                                     M_AXIS_TLAST,
    output logic                                     M_AXIS_TVALID,
    input  wire logic                                M_AXIS_TREADY
);
    import hdc_pkg::*;

    mode_t mode;
    logic [4:0] item_count;
    logic gen_done;
    item_wr_t item_wr;
    item_addr_t rd_addr;
    hv_t rd_data;
    hv_beat_t m_beat;

    // ----------------------------------------------------------------------
    // control registers
    // ----------------------------------------------------------------------

    hdc_axil_regs u_regs (
        .AXIS_ACLK    (AXIS_ACLK),
        .S_AXI_ARESETN(S_AXI_ARESETN),
        .awaddr       (S_AXI_AWADDR),
        .awvalid      (S_AXI_AWVALID),
        .awready      (S_AXI_AWREADY),
        .wdata        (S_AXI_WDATA),
        .wvalid       (S_AXI_WVALID),
        .wready       (S_AXI_WREADY),
        .bvalid       (S_AXI_BVALID),
        .bready       (S_AXI_BREADY),
        .araddr       (S_AXI_ARADDR),
        .arvalid      (S_AXI_ARVALID),
        .arready      (S_AXI_ARREADY),
        .rdata        (S_AXI_RDATA),
        .rvalid       (S_AXI_RVALID),
        .rready       (S_AXI_RREADY),
        .gen_done     (gen_done),
        .mode         (mode),
        .item_count   (item_count)
    );

    // ----------------------------------------------------------------------
    // producer, buffer, consumer
    // ----------------------------------------------------------------------

    hdc_item_gen u_gen (
        .AXIS_ACLK    (AXIS_ACLK),
        .S_AXI_ARESETN(S_AXI_ARESETN),
        .mode         (mode),
        .item_count   (item_count),
        .item_wr      (item_wr),
        .gen_done     (gen_done)
    );

    hdc_item_memory u_mem (
        .AXIS_ACLK(AXIS_ACLK),
        .item_wr  (item_wr),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

    hdc_item_lookup u_lookup (
        .AXIS_ACLK    (AXIS_ACLK),
        .S_AXI_ARESETN(S_AXI_ARESETN),
        .mode         (mode),
        .s_tdata      (S_AXIS_TDATA[$bits(item_addr_t)-1:0]),
        .s_tlast      (S_AXIS_TLAST),
        .s_tvalid     (S_AXIS_TVALID),
        .s_tready     (S_AXIS_TREADY),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .m_beat       (m_beat),
        .m_tvalid     (M_AXIS_TVALID),
        .m_tready     (M_AXIS_TREADY)
    );

    // beat onto the stream fields
    assign M_AXIS_TDATA = m_beat.hv;
    assign M_AXIS_TLAST = m_beat.last;

endmodule

`default_nettype wire

/* verification/tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen (
    output logic AXIS_ACLK,
    output logic S_AXI_ARESETN
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int half_period = 20;
    localparam int reset_cycles = 5;

    // 40 ns free running clock
    initial begin
        AXIS_ACLK = 1'b0;
        forever #(half_period) AXIS_ACLK = ~AXIS_ACLK;
    end

    // low for five rising edges, released on an edge
    initial begin
        S_AXI_ARESETN = 1'b0;
        repeat (reset_cycles) @(posedge AXIS_ACLK);
        S_AXI_ARESETN <= 1'b1;
    end

endmodule

`default_nettype wire

/* verification/hdc_item_props.sv */
`default_nettype none

module hdc_item_props (
    input wire logic                         AXIS_ACLK,
    input wire logic                         S_AXI_ARESETN,
    // output stream
    input wire logic [hdc_pkg::hv_width-1:0] m_tdata,
    input wire logic                         m_tlast,
    input wire logic                         m_tvalid,
    input wire logic                         m_tready,
    // control responses
    input wire logic                         bvalid,
    input wire logic                         bready,
    input wire logic                         rvalid,
    input wire logic                         rready,
    // input stream gate
    input wire logic                         s_tready,
    input wire logic                         run
);
    timeunit 1ns;
    timeprecision 100ps;

    // ----------------------------------------------------------------------
    // stream out holds its beat until taken
    // ----------------------------------------------------------------------

    m_hold: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata) && $stable(m_tlast))
        else $error("M_AXIS beat changed or dropped before it was accepted");

    // ----------------------------------------------------------------------
    // response channels
    // ----------------------------------------------------------------------

    b_hold: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        bvalid && !bready |=> bvalid)
        else $error("BVALID fell before BREADY");

    r_hold: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        rvalid && !rready |=> rvalid)
        else $error("RVALID fell before RREADY");

    // no address beats outside run
    s_gate: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        !(s_tready && !run))
        else $error("S_AXIS_TREADY high while run is low");

endmodule

bind hdc_item_top hdc_item_props u_props (
    .AXIS_ACLK    (AXIS_ACLK),
    .S_AXI_ARESETN(S_AXI_ARESETN),
    .m_tdata      (M_AXIS_TDATA),
    .m_tlast      (M_AXIS_TLAST),
    .m_tvalid     (M_AXIS_TVALID),
    .m_tready     (M_AXIS_TREADY),
    .bvalid       (S_AXI_BVALID),
    .bready       (S_AXI_BREADY),
    .rvalid       (S_AXI_RVALID),
    .rready       (S_AXI_RREADY),
    .s_tready     (S_AXIS_TREADY),
    .run          (mode.run)
);

`default_nettype wire

/* verification/tb_hdc_item_top.sv */
`default_nettype none

module tb_hdc_item_top;
    timeunit 1ns;
    timeprecision 100ps;
    import hdc_pkg::*;

    // one lookup beat and the ready pattern used while it drains
    typedef struct packed {
        logic [3:0] addr;
        logic last;
        logic [1:0] duty;
    } beat_entry_t;

    localparam logic [1:0] duty_full = 2'd0;
    localparam logic [1:0] duty_half = 2'd1;
    localparam logic [1:0] duty_sparse = 2'd2;
    localparam int table_len = 24;
    localparam int clk_period = 40;
    localparam int watchdog_cycles = 40 * (table_len + item_count_max * chunks_per_hv + 200);
    localparam logic [11:0] mode_reg = 12'h000;
    localparam logic [11:0] count_reg = 12'h004;
    localparam logic [11:0] spare_reg = 12'h008;
    localparam logic [31:0] model_seed = 32'd2463534242;

    // every item at least once, a few repeats, frames of varying length
    localparam beat_entry_t beat_table [table_len] = '{
        '{4'd0, 1'b0, duty_full},    '{4'd1, 1'b0, duty_full},
        '{4'd2, 1'b0, duty_half},    '{4'd3, 1'b1, duty_half},
        '{4'd4, 1'b0, duty_half},    '{4'd5, 1'b0, duty_sparse},
        '{4'd6, 1'b0, duty_sparse},  '{4'd7, 1'b1, duty_half},
        '{4'd8, 1'b0, duty_full},    '{4'd9, 1'b0, duty_half},
        '{4'd10, 1'b0, duty_sparse}, '{4'd11, 1'b1, duty_half},
        '{4'd12, 1'b0, duty_half},   '{4'd13, 1'b0, duty_sparse},
        '{4'd14, 1'b0, duty_half},   '{4'd15, 1'b1, duty_full},
        '{4'd15, 1'b0, duty_half},   '{4'd0, 1'b0, duty_sparse},
        '{4'd7, 1'b1, duty_half},    '{4'd3, 1'b0, duty_half},
        '{4'd3, 1'b0, duty_sparse},  '{4'd12, 1'b0, duty_half},
        '{4'd5, 1'b0, duty_full},    '{4'd9, 1'b1, duty_sparse}
    };

    logic AXIS_ACLK;
    logic S_AXI_ARESETN;
    logic [11:0] S_AXI_AWADDR;
    logic S_AXI_AWVALID;
    logic S_AXI_AWREADY;
    logic [31:0] S_AXI_WDATA;
    logic S_AXI_WVALID;
    logic S_AXI_WREADY;
    logic S_AXI_BVALID;
    logic S_AXI_BREADY;
    logic [11:0] S_AXI_ARADDR;
    logic S_AXI_ARVALID;
    logic S_AXI_ARREADY;
    logic [31:0] S_AXI_RDATA;
    logic S_AXI_RVALID;
    logic S_AXI_RREADY;
    logic [31:0] S_AXIS_TDATA;
    logic S_AXIS_TLAST;
    logic S_AXIS_TVALID;
    logic S_AXIS_TREADY;
    logic [hv_width-1:0] M_AXIS_TDATA;
    logic M_AXIS_TLAST;
    logic M_AXIS_TVALID;
    logic M_AXIS_TREADY;

    integer seed;
    int error_count;
    hv_t model_hv [item_count_max];
    beat_entry_t expected_q [$];
    logic [31:0] rd_word;

    tb_clock_gen u_clk (
        .AXIS_ACLK    (AXIS_ACLK),
        .S_AXI_ARESETN(S_AXI_ARESETN)
    );

    hdc_item_top UUT (
        .AXIS_ACLK    (AXIS_ACLK),
        .S_AXI_ARESETN(S_AXI_ARESETN),
        .S_AXI_AWADDR (S_AXI_AWADDR),
        .S_AXI_AWVALID(S_AXI_AWVALID),
        .S_AXI_AWREADY(S_AXI_AWREADY),
        .S_AXI_WDATA  (S_AXI_WDATA),
        .S_AXI_WVALID (S_AXI_WVALID),
        .S_AXI_WREADY (S_AXI_WREADY),
        .S_AXI_BVALID (S_AXI_BVALID),
        .S_AXI_BREADY (S_AXI_BREADY),
        .S_AXI_ARADDR (S_AXI_ARADDR),
        .S_AXI_ARVALID(S_AXI_ARVALID),
        .S_AXI_ARREADY(S_AXI_ARREADY),
        .S_AXI_RDATA  (S_AXI_RDATA),
        .S_AXI_RVALID (S_AXI_RVALID),
        .S_AXI_RREADY (S_AXI_RREADY),
        .S_AXIS_TDATA (S_AXIS_TDATA),
        .S_AXIS_TLAST (S_AXIS_TLAST),
        .S_AXIS_TVALID(S_AXIS_TVALID),
        .S_AXIS_TREADY(S_AXIS_TREADY),
        .M_AXIS_TDATA (M_AXIS_TDATA),
        .M_AXIS_TLAST (M_AXIS_TLAST),
        .M_AXIS_TVALID(M_AXIS_TVALID),
        .M_AXIS_TREADY(M_AXIS_TREADY)
    );

    // ----------------------------------------------------------------------
    // reference model and checks
    // ----------------------------------------------------------------------

    // left 13, right 17, left 5
    function automatic logic [31:0] xorshift_step(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // word n lands in chunk (n-1) mod 4 of item (n-1) div 4
    task automatic build_model();
        logic [31:0] x;
        int i;
        int c;
        x = model_seed;
        for (i = 0; i < item_count_max; i++) begin
            for (c = 0; c < chunks_per_hv; c++) begin
                x = xorshift_step(x);
                model_hv[i][c*chunk_width +: chunk_width] = x;
            end
        end
    endtask

    task automatic check_value(input string name, input logic [127:0] actual,
                               input logic [127:0] expected);
        if (actual !== expected) begin
            error_count++;
            $display("mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display("*** FAILED ***");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic abort_run(input string reason);
        error_count++;
        $display("error at %0t: %s", $time, reason);
        $display("*** FAILED ***");
        $fatal(1, "run aborted");
    endtask

    // ready pattern for one drain cycle
    function automatic logic ready_for_duty(input logic [1:0] duty, input logic [31:0] r);
        case (duty)
            duty_half: return r[0];
            duty_sparse: return (r[1:0] == 2'b00);
            default: return 1'b1;
        endcase
    endfunction

    // ----------------------------------------------------------------------
    // control bus
    // ----------------------------------------------------------------------

    // address and data may be taken on different edges
    task automatic axil_write(input logic [11:0] addr, input logic [31:0] data);
        logic aw_hit;
        logic w_hit;
        logic aw_done;
        logic w_done;
        aw_done = 1'b0;
        w_done = 1'b0;
        @(posedge AXIS_ACLK);
        S_AXI_AWADDR <= addr;
        S_AXI_AWVALID <= 1'b1;
        S_AXI_WDATA <= data;
        S_AXI_WVALID <= 1'b1;
        S_AXI_BREADY <= 1'b1;
        while (!(aw_done && w_done)) begin
            @(negedge AXIS_ACLK);
            aw_hit = S_AXI_AWVALID && S_AXI_AWREADY;
            w_hit = S_AXI_WVALID && S_AXI_WREADY;
            @(posedge AXIS_ACLK);
            if (aw_hit) begin
                S_AXI_AWVALID <= 1'b0;
                aw_done = 1'b1;
            end
            if (w_hit) begin
                S_AXI_WVALID <= 1'b0;
                w_done = 1'b1;
            end
        end
        @(negedge AXIS_ACLK);
        while (!S_AXI_BVALID) @(negedge AXIS_ACLK);
        @(posedge AXIS_ACLK);
        S_AXI_BREADY <= 1'b0;
    endtask

    task automatic axil_read(input logic [11:0] addr, output logic [31:0] data);
        @(posedge AXIS_ACLK);
        S_AXI_ARADDR <= addr;
        S_AXI_ARVALID <= 1'b1;
        S_AXI_RREADY <= 1'b1;
        @(negedge AXIS_ACLK);
        while (!S_AXI_ARREADY) @(negedge AXIS_ACLK);
        @(posedge AXIS_ACLK);
        S_AXI_ARVALID <= 1'b0;
        @(negedge AXIS_ACLK);
        while (!S_AXI_RVALID) @(negedge AXIS_ACLK);
        data = S_AXI_RDATA;
        @(posedge AXIS_ACLK);
        S_AXI_RREADY <= 1'b0;
    endtask

    // poll until gen drops, stream must stay closed meanwhile
    task automatic wait_gen_done();
        logic [31:0] word;
        word = 32'h1;
        while (word[0]) begin
            axil_read(mode_reg, word);
            @(negedge AXIS_ACLK);
            check_value("S_AXIS_TREADY", S_AXIS_TREADY, 1'b0);
        end
        check_value("mode register", word, 32'h0);
    endtask

    // ----------------------------------------------------------------------
    // lookup stream
    // ----------------------------------------------------------------------

    task automatic run_table(input bit random_ready);
        int i;
        int got;
        logic [31:0] r;
        logic [1:0] duty;
        beat_entry_t head;
        fork
            begin
                // sender, queue entry made when the beat is taken
                @(posedge AXIS_ACLK);
                for (i = 0; i < table_len; i++) begin
                    S_AXIS_TDATA <= 32'(beat_table[i].addr);
                    S_AXIS_TLAST <= beat_table[i].last;
                    S_AXIS_TVALID <= 1'b1;
                    @(negedge AXIS_ACLK);
                    while (!S_AXIS_TREADY) @(negedge AXIS_ACLK);
                    expected_q.push_back(beat_table[i]);
                    @(posedge AXIS_ACLK);
                end
                S_AXIS_TVALID <= 1'b0;
            end
            begin
                // receiver, ready follows the duty of the oldest pending beat
                got = 0;
                while (got < table_len) begin
                    @(posedge AXIS_ACLK);
                    duty = (expected_q.size() > 0) ? expected_q[0].duty : duty_full;
                    r = $random(seed);
                    M_AXIS_TREADY <= random_ready ? ready_for_duty(duty, r) : 1'b1;
                    @(negedge AXIS_ACLK);
                    if (M_AXIS_TVALID && M_AXIS_TREADY) begin
                        if (expected_q.size() == 0) begin
                            abort_run("output beat arrived with no input beat pending");
                        end else begin
                            head = expected_q.pop_front();
                            check_value("M_AXIS_TDATA", M_AXIS_TDATA, model_hv[head.addr]);
                            check_value("M_AXIS_TLAST", M_AXIS_TLAST, head.last);
                            got++;
                        end
                    end
                end
            end
        join
        @(posedge AXIS_ACLK);
        M_AXIS_TREADY <= 1'b1;
        // a duplicated beat would surface within the pipeline depth
        repeat (3) begin
            @(negedge AXIS_ACLK);
            check_value("M_AXIS_TVALID", M_AXIS_TVALID, 1'b0);
        end
    endtask

    // ----------------------------------------------------------------------
    // watchdog and main sequence
    // ----------------------------------------------------------------------

    initial begin
        #(watchdog_cycles * clk_period);
        abort_run("timeout, the tests did not finish in time");
    end

    initial begin
        seed = 32'h0ad4_6cba;
        error_count = 0;
        S_AXI_AWADDR = '0;
        S_AXI_AWVALID = 1'b0;
        S_AXI_WDATA = '0;
        S_AXI_WVALID = 1'b0;
        S_AXI_BREADY = 1'b0;
        S_AXI_ARADDR = '0;
        S_AXI_ARVALID = 1'b0;
        S_AXI_RREADY = 1'b0;
        S_AXIS_TDATA = '0;
        S_AXIS_TLAST = 1'b0;
        S_AXIS_TVALID = 1'b0;
        M_AXIS_TREADY = 1'b1;
        build_model();
        wait (S_AXI_ARESETN === 1'b1);
        @(negedge AXIS_ACLK);

        // reset state
        check_value("M_AXIS_TVALID", M_AXIS_TVALID, 1'b0);
        check_value("S_AXI_BVALID", S_AXI_BVALID, 1'b0);
        check_value("S_AXI_RVALID", S_AXI_RVALID, 1'b0);
        check_value("S_AXIS_TREADY", S_AXIS_TREADY, 1'b0);
        axil_read(mode_reg, rd_word);
        check_value("mode register", rd_word, 32'h0);
        axil_read(count_reg, rd_word);
        check_value("count register", rd_word, 32'h0);

        // register access and count clamp
        axil_write(count_reg, 32'd9);
        axil_read(count_reg, rd_word);
        check_value("count register", rd_word, 32'd9);
        axil_write(count_reg, 32'd40);
        axil_read(count_reg, rd_word);
        check_value("count register", rd_word, 32'd16);
        axil_read(spare_reg, rd_word);
        check_value("unmapped register", rd_word, 32'h0);

        // full generation
        axil_write(count_reg, 32'd16);
        axil_write(mode_reg, 32'd1);
        wait_gen_done();

        // lookups, open stream then random back-pressure
        axil_write(mode_reg, 32'd2);
        run_table(1'b0);
        run_table(1'b1);

        // partial regeneration restarts from the seed
        axil_write(count_reg, 32'd5);
        axil_write(mode_reg, 32'd1);
        wait_gen_done();
        axil_write(mode_reg, 32'd2);
        run_table(1'b0);

        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hdc_item.f */
hw/hdc_pkg.sv
hw/axil_pkg.sv
hw/hdc_axil_regs.sv
hw/hdc_item_gen.sv
hw/hdc_item_memory.sv
hw/hdc_item_lookup.sv
hw/hdc_item_top.sv
verification/tb_clock_gen.sv
verification/hdc_item_props.sv
verification/tb_hdc_item_top.sv
